//--- hdl/fetch_bus_pkg.sv
package fetch_bus_pkg;

  // Request from the fetch stage, flush requests carry no address
  typedef struct packed {
    logic        valid;
    logic        flush;
    logic [31:0] addr;
  } core_request_t;

  // Pulsed once per request, instr is zero-extended for compressed
  typedef struct packed {
    logic        ready;
    logic [31:0] instr;
  } core_reply_t;

  // Held high while prefetch wants the word at addr
  typedef struct packed {
    logic        valid;
    logic [31:0] addr;
  } mem_request_t;

  typedef struct packed {
    logic        ready;
    logic [31:0] rdata;
  } mem_reply_t;

endpackage

//--- hdl/fetch_entry_pkg.sv
package fetch_entry_pkg;

  // Widest store index that a write port can carry
  parameter int waddr_width = 8;

  typedef struct packed {
    logic [15:0] hi;
    logic [15:0] lo;
  } fetch_half_t;

  // A buffered word is either one instruction word or two parcels
  typedef union packed {
    logic [31:0] word;
    fetch_half_t half;
  } fetch_word_u;

  // The tag is the full word address of the data
  typedef struct packed {
    logic        valid;
    logic [29:0] tag;
    fetch_word_u data;
  } fetch_entry_t;

  typedef struct packed {
    logic                   wen;
    logic [waddr_width-1:0] waddr;
    fetch_entry_t           entry;
  } store_write_t;

  typedef struct packed {
    logic        hit;
    fetch_word_u word;
  } lookup_t;

endpackage

//--- hdl/fetch_store.sv
module fetch_store #(
  parameter int depth_log2 = 3
) (
  input  logic                          clock,
  input  logic                          reset,
  input  fetch_entry_pkg::store_write_t write,
  input  logic [29:0]                   first_addr,
  input  logic [29:0]                   second_addr,
  output fetch_entry_pkg::lookup_t      first,
  output fetch_entry_pkg::lookup_t      second
);
  import fetch_entry_pkg::*;

  fetch_entry_t entries [2**depth_log2];

  // A word being written this cycle is seen by both read ports
  function automatic lookup_t look_up(input fetch_entry_t stored, input store_write_t wr,
                                      input logic [29:0] addr);
    fetch_entry_t entry;
    lookup_t      result;
    entry = stored;
    if (wr.wen && wr.waddr == waddr_width'(addr[depth_log2-1:0])) begin
      entry = wr.entry;
    end
    result.hit  = entry.valid && entry.tag == addr;
    result.word = entry.data;
    return result;
  endfunction

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < 2**depth_log2; i++) begin
        entries[i].valid <= 1'b0;
      end
    end else if (write.wen) begin
      entries[write.waddr[depth_log2-1:0]] <= write.entry;
    end
  end

  always_comb begin
    first  = look_up(entries[first_addr[depth_log2-1:0]], write, first_addr);
    second = look_up(entries[second_addr[depth_log2-1:0]], write, second_addr);
  end

  // Prefetch must only ever address entries that exist
  write_in_range: assert property (
    @(posedge clock) disable iff (reset)
    write.wen |-> int'(write.waddr) < 2**depth_log2
  );

endmodule

//--- hdl/fetch_prefetch.sv
module fetch_prefetch #(
  parameter int depth_log2 = 3
) (
  input  logic                          clock,
  input  logic                          reset,
  input  fetch_bus_pkg::core_request_t  request,
  input  logic                          miss_pending,
  input  logic [29:0]                   miss_addr,
  input  logic [1:0]                    step,
  input  fetch_bus_pkg::mem_reply_t     mem_reply,
  output fetch_bus_pkg::mem_request_t   mem_request,
  output fetch_entry_pkg::store_write_t write,
  output logic                          flushing
);
  import fetch_bus_pkg::*;
  import fetch_entry_pkg::*;

  // Run-ahead limit in halfwords, two entries are kept as slack
  localparam int max_count = 2 * (2**depth_log2 - 2);

  logic [31:0]           fetch_addr;
  logic [depth_log2:0]   count;
  logic [depth_log2:0]   count_next;
  logic                  sweep;
  logic [depth_log2-1:0] sweep_index;
  logic                  started;
  logic                  flush_start;
  logic                  accept;
  logic                  redirect;

  assign flush_start = request.valid && request.flush;
  assign flushing    = flush_start || sweep;

  assign mem_request.valid = started && count < (depth_log2 + 1)'(max_count);
  assign mem_request.addr  = fetch_addr;

  // Words returned during a flush sweep are dropped and fetched again
  assign accept = mem_request.valid && mem_reply.ready && !flushing;

  // Restart when the missing word is not the next one to be fetched
  assign redirect = miss_pending &&
                    (miss_addr != fetch_addr[31:2] || count >= (depth_log2 + 1)'(max_count));

  always_comb begin
    write = '0;
    if (flushing) begin
      // Sweep index rests at zero, so the request cycle clears entry 0
      write.wen   = 1'b1;
      write.waddr = waddr_width'(sweep_index);
    end else if (accept) begin
      write.wen             = 1'b1;
      write.waddr           = waddr_width'(fetch_addr[depth_log2+1:2]);
      write.entry.valid     = 1'b1;
      write.entry.tag       = fetch_addr[31:2];
      write.entry.data.word = mem_reply.rdata;
    end
  end

  always_comb begin
    count_next = count;
    if (accept) begin
      count_next = count_next + 2'd2;
    end
    if ((depth_log2 + 1)'(step) > count_next) begin
      count_next = '0;
    end else begin
      count_next = count_next - (depth_log2 + 1)'(step);
    end
    if (redirect) begin
      count_next = '0;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      fetch_addr  <= '0;
      count       <= '0;
      sweep       <= 1'b0;
      sweep_index <= '0;
      started     <= 1'b0;
    end else begin
      started <= 1'b1;
      if (flushing) begin
        sweep_index <= sweep_index + 1'b1;
        sweep       <= sweep_index != '1;
        count       <= '0;
      end else begin
        count <= count_next;
      end
      if (redirect) begin
        fetch_addr <= {miss_addr, 2'b00};
      end else if (accept) begin
        fetch_addr <= fetch_addr + 32'd4;
      end
    end
  end

  // Alignment has to survive every redirect and advance
  mem_addr_aligned: assert property (
    @(posedge clock) disable iff (reset)
    mem_request.valid |-> mem_request.addr[1:0] == 2'b00
  );

endmodule

//--- hdl/fetch_align.sv
module fetch_align (
  input  logic                         clock,
  input  logic                         reset,
  input  fetch_bus_pkg::core_request_t request,
  input  fetch_entry_pkg::lookup_t     first,
  input  fetch_entry_pkg::lookup_t     second,
  input  logic                         flushing,
  output logic [29:0]                  first_addr,
  output logic [29:0]                  second_addr,
  output logic                         miss_pending,
  output logic [29:0]                  miss_addr,
  output logic [1:0]                   step,
  output fetch_bus_pkg::core_reply_t   reply
);
  import fetch_bus_pkg::*;
  import fetch_entry_pkg::*;

  logic        pending;
  logic        pending_flush;
  logic [31:0] pending_addr;
  logic        active;
  logic        current_flush;
  logic [31:0] current_addr;
  logic [15:0] head;

  // A fresh request is served directly so buffered hits return at once
  assign active        = request.valid || pending;
  assign current_flush = request.valid ? request.flush : pending_flush;
  assign current_addr  = request.valid ? request.addr : pending_addr;

  assign first_addr  = current_addr[31:2];
  assign second_addr = first_addr + 30'd1;

  assign head = current_addr[1] ? first.word.half.hi : first.word.half.lo;

  always_comb begin
    reply        = '0;
    miss_pending = 1'b0;
    miss_addr    = first_addr;
    step         = 2'd0;
    if (active && current_flush) begin
      reply.ready = !flushing;
    end else if (active) begin
      if (!first.hit) begin
        miss_pending = 1'b1;
      end else if (head[1:0] != 2'b11) begin
        reply.ready = 1'b1;
        reply.instr = {16'h0000, head};
        step        = 2'd1;
      end else if (!current_addr[1]) begin
        reply.ready = 1'b1;
        reply.instr = first.word.word;
        step        = 2'd2;
      end else if (second.hit) begin
        // Upper parcel of a straddling instruction sits in the next word
        reply.ready = 1'b1;
        reply.instr = {second.word.half.lo, head};
        step        = 2'd2;
      end else begin
        miss_pending = 1'b1;
        miss_addr    = second_addr;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      pending       <= 1'b0;
      pending_flush <= 1'b0;
    end else if (request.valid) begin
      pending       <= !reply.ready;
      pending_flush <= request.flush;
    end else if (reply.ready) begin
      pending <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (request.valid) begin
      pending_addr <= request.addr;
    end
  end

  // Entries are being cleared, nothing may be handed to the core
  no_ready_while_flushing: assert property (
    @(posedge clock) disable iff (reset)
    flushing |-> !reply.ready
  );

endmodule

//--- hdl/fetch_buffer.sv
module fetch_buffer #(
  parameter int depth_log2 = 3
) (
  input  logic                         clock,
  input  logic                         reset,
  input  fetch_bus_pkg::core_request_t request,
  output fetch_bus_pkg::core_reply_t   reply,
  output fetch_bus_pkg::mem_request_t  mem_request,
  input  fetch_bus_pkg::mem_reply_t    mem_reply
);
  import fetch_bus_pkg::*;
  import fetch_entry_pkg::*;

  logic [29:0]  first_addr;
  logic [29:0]  second_addr;
  lookup_t      first;
  lookup_t      second;
  store_write_t write;
  logic         miss_pending;
  logic [29:0]  miss_addr;
  logic [1:0]   step;
  logic         flushing;

  fetch_store #(
    .depth_log2 (depth_log2)
  ) i_fetch_store (
    .clock       (clock),
    .reset       (reset),
    .write       (write),
    .first_addr  (first_addr),
    .second_addr (second_addr),
    .first       (first),
    .second      (second)
  );

  fetch_prefetch #(
    .depth_log2 (depth_log2)
  ) i_fetch_prefetch (
    .clock        (clock),
    .reset        (reset),
    .request      (request),
    .miss_pending (miss_pending),
    .miss_addr    (miss_addr),
    .step         (step),
    .mem_reply    (mem_reply),
    .mem_request  (mem_request),
    .write        (write),
    .flushing     (flushing)
  );

  fetch_align i_fetch_align (
    .clock        (clock),
    .reset        (reset),
    .request      (request),
    .first        (first),
    .second       (second),
    .flushing     (flushing),
    .first_addr   (first_addr),
    .second_addr  (second_addr),
    .miss_pending (miss_pending),
    .miss_addr    (miss_addr),
    .step         (step),
    .reply        (reply)
  );

endmodule

//--- testbench/fetch_buffer_tb.sv
module fetch_buffer_tb;
  import fetch_bus_pkg::*;

  localparam int period = 20;
  localparam int cycles_per_case = 200;
  localparam int wait_limit = 100;
  localparam int image_words = 32;
  localparam int request_base = 2 * image_words + 1;
  localparam logic [31:0] flush_marker = 32'hffff_ffff;

  logic          clock;
  logic          reset;
  core_request_t request;
  core_reply_t   reply;
  mem_request_t  mem_request;
  mem_reply_t    mem_reply;

  logic [31:0] case_words [0:127];
  logic        loaded = 1'b0;
  logic [7:0]  lfsr = 8'd50;
  int          mem_delay = 0;
  int          image_base;
  int          request_count;
  int          checks;
  int          errors;

  fetch_buffer #(
    .depth_log2 (3)
  ) i_fetch_buffer (
    .clock       (clock),
    .reset       (reset),
    .request     (request),
    .reply       (reply),
    .mem_request (mem_request),
    .mem_reply   (mem_reply)
  );

  always #(period / 2) clock = ~clock;

  // Fibonacci LFSR with taps 8, 6, 5 and 4
  function automatic logic [7:0] lfsr_step(input logic [7:0] state);
    return {state[6:0], state[7] ^ state[5] ^ state[4] ^ state[3]};
  endfunction

  task automatic compare(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("ERR time %0t %s expected %h actual %h", $time, name, expected, actual);
    end
  endtask

  // Memory answers one or two cycles after it sees a read with data for the current address
  always @(posedge clock) begin
    #2;
    mem_reply = '0;
    if (reset || !mem_request.valid) begin
      mem_delay = 0;
    end else if (mem_delay == 0) begin
      lfsr = lfsr_step(lfsr);
      mem_delay = 1 + int'(lfsr[0]);
    end else begin
      mem_delay--;
      if (mem_delay == 0) begin
        // Reads are whole words, so the byte offset must be zero
        compare("mem_request.addr[1:0]", 32'd0, {30'd0, mem_request.addr[1:0]});
        mem_reply.ready = 1'b1;
        mem_reply.rdata = case_words[image_base + int'(mem_request.addr[6:2])];
      end
    end
  end

  task automatic run_request(input logic [31:0] addr, input logic [31:0] expected);
    logic flush;
    int   waited;
    flush = addr == flush_marker;
    waited = 0;
    @(posedge clock);
    #2;
    request.valid = 1'b1;
    request.flush = flush;
    request.addr  = flush ? 32'd0 : addr;
    if (flush) begin
      image_base = image_words;
    end
    @(negedge clock);
    while (!reply.ready && waited < wait_limit) begin
      @(posedge clock);
      #2;
      request = '0;
      @(negedge clock);
      waited++;
    end
    if (reply.ready) begin
      compare($sformatf("reply.instr for %h", addr), expected, reply.instr);
    end else begin
      errors++;
      $display("No ready within %0d cycles for the request at address %h", wait_limit, addr);
    end
    @(posedge clock);
    #2;
    request = '0;
  endtask

  initial begin
    clock = 1'b0;
    reset = 1'b1;
    request = '0;
    mem_reply = '0;
    image_base = 0;
    checks = 0;
    errors = 0;
    $readmemh("testbench/fetch_cases.txt", case_words);
    request_count = int'(case_words[2 * image_words]);
    loaded = 1'b1;
    repeat (2) @(posedge clock);
    #2;
    reset = 1'b0;
    @(negedge clock);
    compare("reply.ready", 32'd0, {31'd0, reply.ready});
    compare("mem_request.valid", 32'd0, {31'd0, mem_request.valid});
    for (int i = 0; i < request_count; i++) begin
      run_request(case_words[request_base + 2 * i], case_words[request_base + 2 * i + 1]);
    end
    @(posedge clock);
    $display("Checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  initial begin
    wait (loaded);
    #(period * cycles_per_case * (request_count + 1));
    $display("Watchdog expired before all requests were answered");
    $display("Checks %0d errors %0d", checks, errors + 1);
    $display("TB FAILED");
    $finish;
  end

endmodule

//--- testbench/fetch_cases.txt
// Two memory images of 32 words, then the request count, then request lines
// Request line columns: byte address (ffffffff flushes and switches image), expected instr
00500093 05054505 01138082 47850010 00208113 00310193 00418213 00520293
00628313 00730393 00838413 00940493 00a48513 00b50593 00c58613 00d60693
00e68713 00f70793 01078813 01180893 01288913 01390993 014a0a13 015a8a93
016b0b13 017b8b93 018c0c13 019c8c93 02a00513 01bd8d93 01ce0e13 06131234
00700193 00812023 46114501 0041a283 00512223 00628333 40628333 0062a023
10000117 ff010113 00112623 00812423 01010413 00000793 00078513 00c12083
00812403 01010113 00008067 0000006f 00100073 00000000 30200073 10500073
00002197 80018193 00000297 ffc28293 fe0008e3 0000a517 00050513 00008067
0000000d
00000000 00500093
00000004 00004505
00000006 00000505
00000008 00008082
0000000a 00100113
0000000e 00004785
00000070 02a00513
0000007e 00930613
ffffffff 00000000
00000000 00700193
00000004 00812023
00000008 00004501
00000070 fe0008e3

//--- fetch_buffer.f
hdl/fetch_bus_pkg.sv
hdl/fetch_entry_pkg.sv
hdl/fetch_store.sv
hdl/fetch_prefetch.sv
hdl/fetch_align.sv
hdl/fetch_buffer.sv
testbench/fetch_buffer_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module fetch_buffer_tb -Mdir obj_dir -f fetch_buffer.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vfetch_buffer_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "TB PASSED" sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1
